// ==== hdl/dsp_slice_pkg.sv ====
package dsp_slice_pkg;

    // ==================================================
    // Datapath widths
    // ==================================================
    localparam int HALF_W   = 18;   // One multiplier operand
    localparam int WORD_W   = 36;   // One memory word
    localparam int PROD_W   = 36;
    localparam int RES_W    = 54;
    localparam int C_SHIFT  = 18;   // C sits in bits 53..18 of the result
    localparam int PIPE_LAT = 3;    // Input to result, enabled edges

    typedef logic [HALF_W-1:0] operand_t;
    typedef logic [PROD_W-1:0] product_t;
    typedef logic signed [RES_W-1:0] result_t;

    // Memory word, read whole for C or split for the multipliers
    typedef union packed {
        logic [WORD_W-1:0] whole;
        struct packed {
            operand_t hi;
            operand_t lo;
        } half;
    } mem_word_u;

    // ==================================================
    // Operand source select
    // ==================================================
    // 0..3  current mem0.lo, mem0.hi, mem1.lo, mem1.hi
    // 4..7  same halves, previous enabled cycle
    typedef logic [2:0] operand_sel_t;

    localparam operand_sel_t SEL_PREV = 3'd4;

    // ==================================================
    // Post-adder opcodes
    // ==================================================
    typedef enum logic [1:0] {
        OP_SUM_P     = 2'd0,    // pa + pb
        OP_DIFF_P    = 2'd1,    // pa - pb
        OP_SUM_PC    = 2'd2,    // C + pa + pb
        OP_C_MINUS_P = 2'd3     // C - pa - pb
    } alu_op_e;

endpackage

// ==== hdl/dsp_slice_top.sv ====
`timescale 1ns/100ps

module dsp_slice_top (
    input  logic                       CLK0,
    input  logic                       rst_n,
    input  logic                       ce,
    input  logic                       in_valid,
    input  dsp_slice_pkg::mem_word_u    mem0,
    input  dsp_slice_pkg::mem_word_u    mem1,
    input  dsp_slice_pkg::operand_sel_t sel_aa,
    input  dsp_slice_pkg::operand_sel_t sel_ab,
    input  dsp_slice_pkg::operand_sel_t sel_ba,
    input  dsp_slice_pkg::operand_sel_t sel_bb,
    input  logic                       c_sel,
    input  logic                       sign_aa,
    input  logic                       sign_ab,
    input  logic                       sign_ba,
    input  logic                       sign_bb,
    input  dsp_slice_pkg::alu_op_e      opcode,
    output dsp_slice_pkg::result_t      result,
    output logic                       eqz,
    output logic                       over,
    output logic                       res_valid
);
    import dsp_slice_pkg::*;

    operand_t  op_aa;
    operand_t  op_ab;
    operand_t  op_ba;
    operand_t  op_bb;
    mem_word_u c_word;
    product_t  product_a;
    product_t  product_b;
    logic      prod_signed_a;
    logic      prod_signed_b;

    // ==================================================
    // Operand selection
    // ==================================================
    operand_bank u_bank (
        .CLK0   (CLK0),
        .rst_n  (rst_n),
        .ce     (ce),
        .mem0   (mem0),
        .mem1   (mem1),
        .sel_aa (sel_aa),
        .sel_ab (sel_ab),
        .sel_ba (sel_ba),
        .sel_bb (sel_bb),
        .c_sel  (c_sel),
        .op_aa  (op_aa),
        .op_ab  (op_ab),
        .op_ba  (op_ba),
        .op_bb  (op_bb),
        .c_word (c_word)
    );

    // ==================================================
    // Multiplier lanes
    // ==================================================
    mult_lane u_lane_a (
        .CLK0           (CLK0),
        .rst_n          (rst_n),
        .ce             (ce),
        .op_a           (op_aa),
        .op_b           (op_ab),
        .sign_a         (sign_aa),
        .sign_b         (sign_ab),
        .product        (product_a),
        .product_signed (prod_signed_a)
    );

    mult_lane u_lane_b (
        .CLK0           (CLK0),
        .rst_n          (rst_n),
        .ce             (ce),
        .op_a           (op_ba),
        .op_b           (op_bb),
        .sign_a         (sign_ba),
        .sign_b         (sign_bb),
        .product        (product_b),
        .product_signed (prod_signed_b)
    );

    post_adder_alu u_alu (
        .CLK0      (CLK0),
        .rst_n     (rst_n),
        .ce        (ce),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .c_word    (c_word),
        .product_a (product_a),
        .product_b (product_b),
        .signed_a  (prod_signed_a),
        .signed_b  (prod_signed_b),
        .result    (result),
        .eqz       (eqz),
        .over      (over),
        .res_valid (res_valid)
    );

endmodule

// ==== hdl/mult_lane.sv ====
`timescale 1ns/100ps

module mult_lane (
    input  logic                     CLK0,
    input  logic                     rst_n,
    input  logic                     ce,
    input  dsp_slice_pkg::operand_t   op_a,
    input  dsp_slice_pkg::operand_t   op_b,
    input  logic                     sign_a,
    input  logic                     sign_b,
    output dsp_slice_pkg::product_t   product,
    output logic                     product_signed
);
    import dsp_slice_pkg::*;

    operand_t a_q;
    operand_t b_q;
    logic     sa_q;
    logic     sb_q;

    // One extra bit per operand so unsigned values stay positive
    logic signed [HALF_W:0]     a_ext;
    logic signed [HALF_W:0]     b_ext;
    logic signed [2*HALF_W+1:0] mult_full;

    // ==================================================
    // Input register stage
    // ==================================================
    always_ff @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            a_q  <= '0;
            b_q  <= '0;
            sa_q <= 1'b0;
            sb_q <= 1'b0;
        end else if (ce) begin
            a_q  <= op_a;
            b_q  <= op_b;
            sa_q <= sign_a;
            sb_q <= sign_b;
        end
    end

    assign a_ext     = {sa_q & a_q[HALF_W-1], a_q};
    assign b_ext     = {sb_q & b_q[HALF_W-1], b_q};
    assign mult_full = a_ext * b_ext;

    // Product register, 36 bits hold every sign combination
    always_ff @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            product        <= '0;
            product_signed <= 1'b0;
        end else if (ce) begin
            product        <= mult_full[PROD_W-1:0];
            product_signed <= sa_q | sb_q;
        end
    end

endmodule

// ==== hdl/operand_bank.sv ====
`timescale 1ns/100ps

module operand_bank (
    input  logic                       CLK0,
    input  logic                       rst_n,
    input  logic                       ce,
    input  dsp_slice_pkg::mem_word_u    mem0,
    input  dsp_slice_pkg::mem_word_u    mem1,
    input  dsp_slice_pkg::operand_sel_t sel_aa,
    input  dsp_slice_pkg::operand_sel_t sel_ab,
    input  dsp_slice_pkg::operand_sel_t sel_ba,
    input  dsp_slice_pkg::operand_sel_t sel_bb,
    input  logic                       c_sel,
    output dsp_slice_pkg::operand_t     op_aa,
    output dsp_slice_pkg::operand_t     op_ab,
    output dsp_slice_pkg::operand_t     op_ba,
    output dsp_slice_pkg::operand_t     op_bb,
    output dsp_slice_pkg::mem_word_u    c_word
);
    import dsp_slice_pkg::*;

    mem_word_u mem0_q;      // Words from the last enabled edge
    mem_word_u mem1_q;
    operand_t  half_tbl [8];

    // ==================================================
    // Previous words and C capture
    // ==================================================
    always_ff @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            mem0_q <= '0;
            mem1_q <= '0;
            c_word <= '0;
        end else if (ce) begin
            mem0_q       <= mem0;
            mem1_q       <= mem1;
            c_word.whole <= c_sel ? mem1.whole : mem0.whole;
        end
    end

    // Half-word table, current words first
    always_comb begin
        half_tbl[0] = mem0.half.lo;
        half_tbl[1] = mem0.half.hi;
        half_tbl[2] = mem1.half.lo;
        half_tbl[3] = mem1.half.hi;
        half_tbl[SEL_PREV + 0] = mem0_q.half.lo;
        half_tbl[SEL_PREV + 1] = mem0_q.half.hi;
        half_tbl[SEL_PREV + 2] = mem1_q.half.lo;
        half_tbl[SEL_PREV + 3] = mem1_q.half.hi;
    end

    // ==================================================
    // Operand muxes, no register here
    // ==================================================
    assign op_aa = half_tbl[sel_aa];
    assign op_ab = half_tbl[sel_ab];
    assign op_ba = half_tbl[sel_ba];
    assign op_bb = half_tbl[sel_bb];

endmodule

// ==== hdl/post_adder_alu.sv ====
`timescale 1ns/100ps

module post_adder_alu (
    input  logic                     CLK0,
    input  logic                     rst_n,
    input  logic                     ce,
    input  logic                     in_valid,
    input  dsp_slice_pkg::alu_op_e    opcode,
    input  dsp_slice_pkg::mem_word_u  c_word,
    input  dsp_slice_pkg::product_t   product_a,
    input  dsp_slice_pkg::product_t   product_b,
    input  logic                     signed_a,
    input  logic                     signed_b,
    output dsp_slice_pkg::result_t    result,
    output logic                     eqz,
    output logic                     over,
    output logic                     res_valid
);
    import dsp_slice_pkg::*;

    localparam int DLY = PIPE_LAT - 1;     // Stages ahead of the ALU register

    alu_op_e      op_pipe [DLY];
    logic [DLY-1:0] vld_pipe;
    mem_word_u    c_q;

    // Two guard bits above the result for overflow
    logic signed [RES_W+1:0] prod_a_ext;
    logic signed [RES_W+1:0] prod_b_ext;
    logic signed [RES_W+1:0] c_term;
    logic signed [RES_W+1:0] sum;
    logic                    sum_ovf;
    result_t                 sum_trunc;

    // ==================================================
    // Alignment with the multiplier pipeline
    // ==================================================
    always_ff @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                op_pipe[i] <= OP_SUM_P;
            end
            vld_pipe <= '0;
            c_q      <= '0;
        end else if (ce) begin
            op_pipe[0] <= opcode;
            for (int i = 1; i < DLY; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
            vld_pipe <= {vld_pipe[DLY-2:0], in_valid};
            c_q      <= c_word;     // Already one stage late from the bank
        end
    end

    // ==================================================
    // Term extension and post-adder
    // ==================================================
    always_comb begin
        if (signed_a) begin
            prod_a_ext = {{(RES_W+2-PROD_W){product_a[PROD_W-1]}}, product_a};
        end else begin
            prod_a_ext = {{(RES_W+2-PROD_W){1'b0}}, product_a};
        end

        if (signed_b) begin
            prod_b_ext = {{(RES_W+2-PROD_W){product_b[PROD_W-1]}}, product_b};
        end else begin
            prod_b_ext = {{(RES_W+2-PROD_W){1'b0}}, product_b};
        end

        // C is signed, shifted up to its column
        c_term = {{(RES_W+2-WORD_W-C_SHIFT){c_q.whole[WORD_W-1]}},
                  c_q.whole, {C_SHIFT{1'b0}}};
    end

    always_comb begin
        sum = '0;
        unique case (op_pipe[DLY-1])
            OP_SUM_P:     sum = prod_a_ext + prod_b_ext;
            OP_DIFF_P:    sum = prod_a_ext - prod_b_ext;
            OP_SUM_PC:    sum = c_term + prod_a_ext + prod_b_ext;
            OP_C_MINUS_P: sum = c_term - prod_a_ext - prod_b_ext;
            default:      sum = '0;
        endcase
    end

    // Out of range unless the top three bits agree
    assign sum_ovf   = sum[RES_W+1:RES_W-1] != {3{sum[RES_W-1]}};
    assign sum_trunc = sum[RES_W-1:0];

    // ==================================================
    // Result and flag register
    // ==================================================
    always_ff @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            result    <= '0;
            eqz       <= 1'b0;
            over      <= 1'b0;
            res_valid <= 1'b0;
        end else if (ce) begin
            res_valid <= vld_pipe[DLY-1];
            if (vld_pipe[DLY-1]) begin      // Idle slots keep the last result
                result <= sum_trunc;
                eqz    <= sum_trunc == '0;
                over   <= sum_ovf;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DSP slice testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --assert -Wno-fatal \
    --top-module dsp_slice_tb \
    -Mdir "$BUILD_DIR" \
    -f src.f

# A failing run exits nonzero, the log decides the outcome
"./$BUILD_DIR/Vdsp_slice_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== src.f ====
hdl/dsp_slice_pkg.sv
hdl/operand_bank.sv
hdl/mult_lane.sv
hdl/post_adder_alu.sv
hdl/dsp_slice_top.sv
tests/dsp_slice_tb.sv

// ==== tests/dsp_slice_tb.sv ====
`timescale 1ns/100ps

module dsp_slice_tb;
    import dsp_slice_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int N_SEL          = 12;
    localparam int N_RAND         = 150;
    localparam int MAX_STALL      = 3;
    localparam int N_FLAG_RAND    = 64;
    localparam int DRAIN_CYCLES   = 8;     // Per drain, pipeline plus margin
    localparam int PLANNED_CYCLES = RESET_CYCLES + (4 * 5 + 4) + N_SEL + 4
                                  + N_RAND * (MAX_STALL + 1) + N_FLAG_RAND
                                  + 4 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    localparam longint RES_MAX = (longint'(1) <<< (RES_W - 1)) - 1;
    localparam longint RES_MIN = -(longint'(1) <<< (RES_W - 1));

    logic         CLK0 = 1'b0;
    logic         rst_n;
    logic         ce;
    logic         in_valid;
    mem_word_u    mem0;
    mem_word_u    mem1;
    operand_sel_t sel_aa;
    operand_sel_t sel_ab;
    operand_sel_t sel_ba;
    operand_sel_t sel_bb;
    logic         c_sel;
    logic         sign_aa;
    logic         sign_ab;
    logic         sign_ba;
    logic         sign_bb;
    alu_op_e      opcode;
    result_t      result;
    logic         eqz;
    logic         over;
    logic         res_valid;

    integer seed;
    int     cycle_cnt = 0;

    // Reference model state
    logic [WORD_W-1:0]   prev0;
    logic [WORD_W-1:0]   prev1;
    logic [PIPE_LAT-1:0] vld_sh;
    logic [RES_W+1:0]    exp_q [$];    // {over, eqz, result}
    logic [RES_W+1:0]    exp_item;
    logic [RES_W-1:0]    exp_result;
    logic                exp_eqz;
    logic                exp_over;
    int                  n_pushed;
    int                  n_seen;
    logic                got_valid;    // First result has come out

    // Outputs one edge back, for the hold check
    logic    ce_q;
    result_t result_q;
    logic    eqz_q;
    logic    over_q;
    logic    valid_q;

    dsp_slice_top dut (
        .CLK0      (CLK0),
        .rst_n     (rst_n),
        .ce        (ce),
        .in_valid  (in_valid),
        .mem0      (mem0),
        .mem1      (mem1),
        .sel_aa    (sel_aa),
        .sel_ab    (sel_ab),
        .sel_ba    (sel_ba),
        .sel_bb    (sel_bb),
        .c_sel     (c_sel),
        .sign_aa   (sign_aa),
        .sign_ab   (sign_ab),
        .sign_ba   (sign_ba),
        .sign_bb   (sign_bb),
        .opcode    (opcode),
        .result    (result),
        .eqz       (eqz),
        .over      (over),
        .res_valid (res_valid)
    );

    always #10 CLK0 = ~CLK0;

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [HALF_W-1:0] pick_half(input operand_sel_t sel,
            input logic [WORD_W-1:0] m0, input logic [WORD_W-1:0] m1,
            input logic [WORD_W-1:0] p0, input logic [WORD_W-1:0] p1);
        logic [WORD_W-1:0] w;
        w = sel[1] ? (sel[2] ? p1 : m1) : (sel[2] ? p0 : m0);
        return sel[0] ? w[WORD_W-1:HALF_W] : w[HALF_W-1:0];
    endfunction

    function automatic longint operand_value(input logic [HALF_W-1:0] op, input logic sgn);
        if (sgn) begin
            return {{(64-HALF_W){op[HALF_W-1]}}, op};
        end
        return {{(64-HALF_W){1'b0}}, op};
    endfunction

    function automatic logic [RES_W+1:0] expect_item(
            input logic [WORD_W-1:0] m0, input logic [WORD_W-1:0] m1,
            input logic [WORD_W-1:0] p0, input logic [WORD_W-1:0] p1,
            input logic [11:0] sels, input logic [3:0] signs,
            input logic csel, input alu_op_e op);
        longint           pa;
        longint           pb;
        longint           c_term;
        longint           exact;
        logic [RES_W-1:0] trunc;
        logic             ovf;
        pa = operand_value(pick_half(sels[11:9], m0, m1, p0, p1), signs[3])
           * operand_value(pick_half(sels[8:6], m0, m1, p0, p1), signs[2]);
        pb = operand_value(pick_half(sels[5:3], m0, m1, p0, p1), signs[1])
           * operand_value(pick_half(sels[2:0], m0, m1, p0, p1), signs[0]);
        c_term = csel ? {{(64-WORD_W){m1[WORD_W-1]}}, m1} : {{(64-WORD_W){m0[WORD_W-1]}}, m0};
        c_term = c_term * (longint'(1) << C_SHIFT);   // C times 2^18
        case (op)
            OP_SUM_P:  exact = pa + pb;
            OP_DIFF_P: exact = pa - pb;
            OP_SUM_PC: exact = c_term + pa + pb;
            default:   exact = c_term - pa - pb;
        endcase
        ovf   = (exact > RES_MAX) || (exact < RES_MIN);
        trunc = exact[RES_W-1:0];
        return {ovf, trunc == '0, trunc};
    endfunction

    always @(posedge CLK0 or negedge rst_n) begin
        if (!rst_n) begin
            prev0      <= '0;
            prev1      <= '0;
            vld_sh     <= '0;
            exp_result <= '0;
            exp_eqz    <= 1'b0;
            exp_over   <= 1'b0;
            n_pushed   <= 0;
            n_seen     <= 0;
            got_valid  <= 1'b0;
            exp_q.delete();
        end else if (ce) begin
            if (in_valid) begin
                exp_q.push_back(expect_item(mem0.whole, mem1.whole, prev0, prev1,
                    {sel_aa, sel_ab, sel_ba, sel_bb}, {sign_aa, sign_ab, sign_ba, sign_bb},
                    c_sel, opcode));
                n_pushed <= n_pushed + 1;
            end
            if (vld_sh[PIPE_LAT-2]) begin     // Item entering the result stage
                exp_item   = exp_q.pop_front();
                exp_result <= exp_item[RES_W-1:0];
                exp_eqz    <= exp_item[RES_W];
                exp_over   <= exp_item[RES_W+1];
            end
            if (res_valid) begin
                n_seen    <= n_seen + 1;
                got_valid <= 1'b1;
            end
            vld_sh <= {vld_sh[PIPE_LAT-2:0], in_valid};
            prev0  <= mem0.whole;
            prev1  <= mem1.whole;
        end
    end

    always @(posedge CLK0) begin
        ce_q     <= ce;
        result_q <= result;
        eqz_q    <= eqz;
        over_q   <= over;
        valid_q  <= res_valid;
    end

    // ==================================================
    // Checks
    // ==================================================
    task automatic fail_check(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "Check failed");
    endtask

    chk_reset: assert property (@(posedge CLK0)
        !rst_n |-> (!res_valid && !eqz && !over && result == '0))
        else fail_check("outputs not cleared during reset");
    chk_idle: assert property (@(posedge CLK0) disable iff (!rst_n)
        (!got_valid && !res_valid) |-> (!eqz && !over && result == '0))
        else fail_check("outputs not clear before the first result");
    chk_valid: assert property (@(posedge CLK0) disable iff (!rst_n)
        res_valid == vld_sh[PIPE_LAT-1])
        else fail_check("res_valid out of step with the expected latency");
    chk_result: assert property (@(posedge CLK0) disable iff (!rst_n)
        res_valid |-> result == exp_result)
        else fail_check("result differs from the model");
    chk_eqz: assert property (@(posedge CLK0) disable iff (!rst_n)
        res_valid |-> eqz == exp_eqz)
        else fail_check("eqz differs from the model");
    chk_over: assert property (@(posedge CLK0) disable iff (!rst_n)
        res_valid |-> over == exp_over)
        else fail_check("over differs from the model");
    chk_hold: assert property (@(posedge CLK0) disable iff (!rst_n)
        !ce_q |-> (result == result_q && eqz == eqz_q && over == over_q
                   && res_valid == valid_q))
        else fail_check("outputs changed while ce was low");

    always @(posedge CLK0) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing",
                     TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    function automatic logic [WORD_W-1:0] random_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[WORD_W-1:0];
    endfunction

    task automatic drive_item(input logic valid, input logic [WORD_W-1:0] m0,
            input logic [WORD_W-1:0] m1, input logic [11:0] sels,
            input logic [3:0] signs, input logic csel, input alu_op_e op);
        @(negedge CLK0);
        ce         = 1'b1;
        in_valid   = valid;
        mem0.whole = m0;
        mem1.whole = m1;
        {sel_aa, sel_ab, sel_ba, sel_bb}     = sels;
        {sign_aa, sign_ab, sign_ba, sign_bb} = signs;
        c_sel  = csel;
        opcode = op;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge CLK0);
            ce       = 1'b1;
            in_valid = 1'b0;
        end
    endtask

    // Inputs keep moving during a stall, none of it may land
    task automatic drive_stall(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge CLK0);
            r          = $random(seed);
            ce         = 1'b0;
            in_valid   = r[0];
            mem0.whole = random_word();
            mem1.whole = random_word();
            opcode     = alu_op_e'(r[2:1]);
        end
    endtask

    task automatic drain_pipeline();
        drive_idle(1);
        while (exp_q.size() != 0 || vld_sh != '0) drive_idle(1);
        drive_idle(2);
    endtask

    task automatic run_products();
        logic [WORD_W-1:0] m0 [4];
        logic [WORD_W-1:0] m1 [4];
        logic [3:0]        sg [4];
        alu_op_e           op [4];
        m0[0] = {18'h3FFFD, 18'h00005};  // -3, 5
        m1[0] = {18'h00007, 18'h20000};
        sg[0] = 4'b1111;
        op[0] = OP_SUM_P;
        m0[1] = 36'hF_FFFF_FFFF;        // Unsigned maximum
        m1[1] = 36'hF_FFFF_FFFF;
        sg[1] = 4'b0000;
        op[1] = OP_SUM_P;
        m0[2] = {18'h3FFFF, 18'h3FFFF};
        m1[2] = {18'h20000, 18'h1FFFF};
        sg[2] = 4'b1001;                // Mixed signs per lane
        op[2] = OP_DIFF_P;
        m0[3] = {18'h20000, 18'h20000};
        m1[3] = {18'h20000, 18'h20000};
        sg[3] = 4'b1111;
        op[3] = OP_DIFF_P;
        for (int i = 0; i < 4; i++) begin
            drive_item(1'b1, m0[i], m1[i], 12'o0123, sg[i], 1'b0, op[i]);
            drive_idle(4);
        end
        for (int i = 0; i < 4; i++) begin
            drive_item(1'b1, m0[i], m1[i], 12'o0123, sg[i], 1'b0, op[i]);
        end
        drain_pipeline();
    endtask

    task automatic run_operand_select();
        logic [11:0] sels;
        for (int k = 0; k < N_SEL; k++) begin
            case (k % 4)
                0:       sels = 12'o4567;
                1:       sels = 12'o7654;
                2:       sels = 12'o0437;
                default: sels = 12'o5261;
            endcase
            drive_item(1'b1, random_word(), random_word(), sels, 4'(k),
                       k[1], k[0] ? OP_C_MINUS_P : OP_SUM_PC);
        end
        drain_pipeline();
    endtask

    task automatic run_random_stream();
        logic [31:0] r;
        logic [2:0]  stall;
        for (int i = 0; i < N_RAND; i++) begin
            r     = $random(seed);
            stall = (r[2:0] > 3'(MAX_STALL)) ? 3'd0 : r[2:0];
            drive_stall(int'(stall));
            r = $random(seed);
            drive_item(r[2:0] != 3'd0, random_word(), random_word(), r[14:3],
                       r[18:15], r[19], alu_op_e'(r[21:20]));
        end
        drain_pipeline();
    endtask

    task automatic run_flags();
        logic [31:0]       r;
        logic [WORD_W-1:0] c;
        drive_item(1'b1, random_word(), random_word(), 12'o0101, 4'b1111, 1'b0, OP_DIFF_P);
        drive_item(1'b1, '0, '0, 12'o0123, 4'b0000, 1'b0, OP_SUM_PC);
        // C at the top of its range, then the bottom
        drive_item(1'b1, 36'h7_FFFF_FFFF, 36'hF_FFFF_FFFF, 12'o2323, 4'b0000,
                   1'b0, OP_SUM_PC);
        drive_item(1'b1, 36'h8_0000_0000, 36'hF_FFFF_FFFF, 12'o2323, 4'b0000,
                   1'b0, OP_C_MINUS_P);
        for (int i = 0; i < N_FLAG_RAND; i++) begin
            r = $random(seed);
            c = random_word();
            c[WORD_W-1:WORD_W-4] = r[0] ? 4'h7 : 4'h8;
            drive_item(1'b1, c, random_word(), 12'o2323, r[4:1], 1'b0,
                       r[5] ? OP_C_MINUS_P : OP_SUM_PC);
        end
        drain_pipeline();
    endtask

    initial begin
        seed       = 32'hc3e5;
        rst_n      = 1'b0;
        ce         = 1'b0;
        in_valid   = 1'b0;
        mem0.whole = '0;
        mem1.whole = '0;
        sel_aa     = '0;
        sel_ab     = '0;
        sel_ba     = '0;
        sel_bb     = '0;
        c_sel      = 1'b0;
        sign_aa    = 1'b0;
        sign_ab    = 1'b0;
        sign_ba    = 1'b0;
        sign_bb    = 1'b0;
        opcode     = OP_SUM_P;
        repeat (RESET_CYCLES) @(negedge CLK0);
        rst_n = 1'b1;

        run_products();
        run_operand_select();
        run_random_stream();
        run_flags();

        if (n_seen != n_pushed || exp_q.size() != 0) begin
            $display("Result count wrong: %0d items sent, %0d results seen",
                     n_pushed, n_seen);
            $display("*** FAILED ***");
            $fatal(1, "Result count");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
